/* files.f */
+incdir+logic
logic/soc_bus_pkg.sv
logic/soc_map_pkg.sv
logic/lsb_decode.sv
logic/data_mem.sv
logic/gpio_regs.sv
logic/lsb_response.sv
logic/r5p_soc_top.sv
verification/soc_tb.sv

/* logic/data_mem.sv */
`include "soc_macros.svh"

module data_mem (
  input  logic                   clk,
  input  logic                   reset,
  // strobed request
  input  logic                   mem_vld,
  input  logic                   lsb_wen,
  input  soc_bus_pkg::soc_adr_t  lsb_adr,
  input  soc_bus_pkg::soc_ben_t  lsb_ben,
  input  soc_bus_pkg::soc_data_t lsb_wdt,
  // read data, one cycle later
  output soc_bus_pkg::soc_data_t mem_rdt
);

  import soc_bus_pkg::*;

  // word index below the byte lane bits
  localparam int unsigned LBW = $clog2(`SOC_DBW);
  localparam int unsigned WAW = `SOC_RAW - LBW;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  soc_data_t mem [0:`SOC_MEM_WORDS-1];  // contents survive reset

  logic [WAW-1:0] widx;  // word address

  assign widx = lsb_adr.mem.off[`SOC_RAW-1:LBW];

  // byte enabled write
  always_ff @(posedge clk) begin
    if (mem_vld && lsb_wen) begin
      for (int b = 0; b < `SOC_DBW; b++) begin
        if (lsb_ben[b]) mem[widx][8*b+:8] <= lsb_wdt[8*b+:8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // registered, full word regardless of byte enables
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_rdt <= '0;
    end else if (mem_vld && !lsb_wen) begin
      mem_rdt <= mem[widx];
    end else begin
      mem_rdt <= '0;  // writes and idle cycles return zero
    end
  end

endmodule: data_mem

/* logic/gpio_regs.sv */
`include "soc_macros.svh"

module gpio_regs (
  input  logic                   clk,
  input  logic                   reset,
  // strobed request
  input  logic                   gpio_vld,
  input  logic                   lsb_wen,
  input  soc_bus_pkg::soc_adr_t  lsb_adr,
  input  soc_bus_pkg::soc_ben_t  lsb_ben,
  input  soc_bus_pkg::soc_data_t lsb_wdt,
  // read data, one cycle later
  output soc_bus_pkg::soc_data_t gpio_rdt,
  // pins
  output logic [`SOC_GW-1:0]     gpio_o,
  output logic [`SOC_GW-1:0]     gpio_e,
  input  logic [`SOC_GW-1:0]     gpio_i
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  gpio_reg_t         widx;       // register word index
  logic [`SOC_GW-1:0] gpio_meta; // first sync stage
  logic [`SOC_GW-1:0] gpio_sync; // input register
  soc_data_t         rd_word;   // selected register

  // low two offset bits select a byte, not a register
  assign widx = gpio_reg_t'(lsb_adr.per.ofs[5:2]);

  //////////////////////////////////////////////////////////////////////
  // output and enable registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (gpio_vld && lsb_wen) begin
      for (int b = 0; b < `SOC_DBW; b++) begin
        if (lsb_ben[b]) begin
          case (widx)
            gpio_reg_out: gpio_o[8*b+:8] <= lsb_wdt[8*b+:8];
            gpio_reg_ena: gpio_e[8*b+:8] <= lsb_wdt[8*b+:8];
            default: ;  // input reg and holes are read only
          endcase
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // input synchronizer
  //////////////////////////////////////////////////////////////////////

  // two flops, pins are asynchronous to clk
  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_meta <= '0;
      gpio_sync <= '0;
    end else begin
      gpio_meta <= gpio_i;
      gpio_sync <= gpio_meta;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (widx)
      gpio_reg_out: rd_word = gpio_o;
      gpio_reg_ena: rd_word = gpio_e;
      gpio_reg_inp: rd_word = gpio_sync;
      default:      rd_word = '0;  // unused offsets read zero, no error
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      gpio_rdt <= '0;
    end else if (gpio_vld && !lsb_wen) begin
      gpio_rdt <= rd_word;
    end else begin
      gpio_rdt <= '0;
    end
  end

endmodule: gpio_regs

/* logic/lsb_decode.sv */
module lsb_decode (
  // request from the bus master
  input  logic                     lsb_vld,
  input  logic                     lsb_wen,
  input  soc_bus_pkg::soc_adr_t    lsb_adr,
  // target strobes
  output logic                     mem_vld,
  output logic                     gpio_vld,
  // to the response stage
  output soc_map_pkg::soc_region_t req_region,
  output logic                     req_rd
);

  import soc_map_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!lsb_adr.mem.sel) begin
      req_region = reg_mem;   // lower half is memory
    end else if (!lsb_adr.per.dev) begin
      req_region = reg_gpio;  // 0x00..0x3f in the upper half
    end else begin
      req_region = reg_uart;  // 0x40..0x7f, no controller behind it
    end
  end

  //////////////////////////////////////////////////////////////////////
  // target strobes
  //////////////////////////////////////////////////////////////////////

  // uart region strobes nothing
  assign mem_vld  = lsb_vld && (req_region == reg_mem);
  assign gpio_vld = lsb_vld && (req_region == reg_gpio);

  // read flag, response stage zeroes write data
  assign req_rd = lsb_vld && !lsb_wen;

endmodule: lsb_decode

/* logic/lsb_response.sv */
module lsb_response (
  input  logic                     clk,
  input  logic                     reset,
  // request side, current cycle
  input  logic                     lsb_vld,
  input  soc_map_pkg::soc_region_t req_region,
  input  logic                     req_rd,
  // target read data, already one cycle late
  input  soc_bus_pkg::soc_data_t   mem_rdt,
  input  soc_bus_pkg::soc_data_t   gpio_rdt,
  // response to the bus master
  output soc_bus_pkg::soc_data_t   lsb_rdt,
  output logic                     lsb_err
);

  import soc_map_pkg::*;

  soc_region_t rsp_sel;  // region of last cycle's request
  logic        rsp_rd;   // last request was a read

  //////////////////////////////////////////////////////////////////////
  // response state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_sel <= reg_mem;
      rsp_rd  <= 1'b0;
      lsb_err <= 1'b0;
    end else begin
      rsp_sel <= req_region;
      rsp_rd  <= req_rd;
      lsb_err <= lsb_vld && (req_region == reg_uart);  // uart window not populated
    end
  end

  // read data mux, zero for writes and errors
  always_comb begin
    lsb_rdt = '0;
    if (rsp_rd) begin
      case (rsp_sel)
        reg_mem:  lsb_rdt = mem_rdt;
        reg_gpio: lsb_rdt = gpio_rdt;
        default:  lsb_rdt = '0;
      endcase
    end
  end

  // uart window strobes no target, so no target answers with data
  a_err_data: assert property (
    @(posedge clk) disable iff (reset)
    lsb_err |-> (mem_rdt == '0 && gpio_rdt == '0)
  ) else $error("lsb_response: target data alongside an error");

endmodule: lsb_response

/* logic/r5p_soc_top.sv */
`include "soc_macros.svh"

module r5p_soc_top (
  // system
  input  logic                   clk,
  input  logic                   reset,
  // load/store bus, driven by an external master
  input  logic                   lsb_vld,
  input  logic                   lsb_wen,
  input  soc_bus_pkg::soc_adr_t  lsb_adr,
  input  soc_bus_pkg::soc_ben_t  lsb_ben,
  input  soc_bus_pkg::soc_data_t lsb_wdt,
  output soc_bus_pkg::soc_data_t lsb_rdt,
  output logic                   lsb_err,
  // gpio pins
  output logic [`SOC_GW-1:0]     gpio_o,
  output logic [`SOC_GW-1:0]     gpio_e,
  input  logic [`SOC_GW-1:0]     gpio_i
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic        mem_vld;     // memory strobe
  logic        gpio_vld;    // gpio strobe
  soc_region_t req_region;  // decoded target
  logic        req_rd;      // read request
  soc_data_t   mem_rdt;
  soc_data_t   gpio_rdt;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  lsb_decode dec (
    .lsb_vld    (lsb_vld),
    .lsb_wen    (lsb_wen),
    .lsb_adr    (lsb_adr),
    .mem_vld    (mem_vld),
    .gpio_vld   (gpio_vld),
    .req_region (req_region),
    .req_rd     (req_rd)
  );

  //////////////////////////////////////////////////////////////////////
  // targets
  //////////////////////////////////////////////////////////////////////

  data_mem dmem (
    .clk     (clk),
    .reset   (reset),
    .mem_vld (mem_vld),
    .lsb_wen (lsb_wen),
    .lsb_adr (lsb_adr),
    .lsb_ben (lsb_ben),
    .lsb_wdt (lsb_wdt),
    .mem_rdt (mem_rdt)
  );

  gpio_regs gpio (
    .clk      (clk),
    .reset    (reset),
    .gpio_vld (gpio_vld),
    .lsb_wen  (lsb_wen),
    .lsb_adr  (lsb_adr),
    .lsb_ben  (lsb_ben),
    .lsb_wdt  (lsb_wdt),
    .gpio_rdt (gpio_rdt),
    .gpio_o   (gpio_o),
    .gpio_e   (gpio_e),
    .gpio_i   (gpio_i)
  );

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  lsb_response rsp (
    .clk        (clk),
    .reset      (reset),
    .lsb_vld    (lsb_vld),
    .req_region (req_region),
    .req_rd     (req_rd),
    .mem_rdt    (mem_rdt),
    .gpio_rdt   (gpio_rdt),
    .lsb_rdt    (lsb_rdt),
    .lsb_err    (lsb_err)
  );

endmodule: r5p_soc_top

/* logic/soc_bus_pkg.sv */
`include "soc_macros.svh"

package soc_bus_pkg;

  // data word and byte lanes
  typedef logic [`SOC_DDW-1:0] soc_data_t;
  typedef logic [`SOC_DBW-1:0] soc_ben_t;

  //////////////////////////////////////////////////////////////////////
  // address views
  //////////////////////////////////////////////////////////////////////

  // memory half, byte offset into the data memory
  typedef struct packed {
    logic               sel;  // region select, 0 for memory
    logic [`SOC_RAW-1:0] off; // byte offset
  } soc_adr_mem_t;

  // peripheral half
  typedef struct packed {
    logic       sel;  // region select, 1 for peripherals
    logic [6:0] rsv;  // not decoded
    logic       dev;  // 0 gpio, 1 uart
    logic [5:0] ofs;  // register byte offset
  } soc_adr_per_t;

  // one address word, two decodings
  typedef union packed {
    soc_adr_mem_t mem;
    soc_adr_per_t per;
  } soc_adr_t;

endpackage: soc_bus_pkg

/* logic/soc_macros.svh */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// load/store bus widths
//////////////////////////////////////////////////////////////////////

`define SOC_DAW 15  // byte address width
`define SOC_DDW 32  // data width
`define SOC_DBW 4   // byte enables, one per byte lane

//////////////////////////////////////////////////////////////////////
// data memory and peripherals
//////////////////////////////////////////////////////////////////////

`define SOC_RAW 14          // memory window, lower half of the map
`define SOC_MEM_WORDS 4096  // 2**(SOC_RAW-2) words
`define SOC_GW 32           // gpio pin count

// gpio register byte offsets
`define SOC_GPIO_OUT 6'h00
`define SOC_GPIO_ENA 6'h04
`define SOC_GPIO_INP 6'h08

`endif

/* logic/soc_map_pkg.sv */
`include "soc_macros.svh"

package soc_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////////////

  // target of a request
  typedef enum logic [1:0] {
    reg_mem  = 2'd0,  // data memory
    reg_gpio = 2'd1,  // gpio controller
    reg_uart = 2'd2   // uart window, answers with error
  } soc_region_t;

  // gpio register word index (byte offset / 4)
  typedef enum logic [3:0] {
    gpio_reg_out = 4'(`SOC_GPIO_OUT >> 2),  // output data
    gpio_reg_ena = 4'(`SOC_GPIO_ENA >> 2),  // output enable
    gpio_reg_inp = 4'(`SOC_GPIO_INP >> 2)   // synchronized input
  } gpio_reg_t;

endpackage: soc_map_pkg

/* verification/soc_tb.sv */
`include "soc_macros.svh"

module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import soc_bus_pkg::*;

  localparam logic [14:0] GPIO_BASE = 15'h4000;  // upper half, dev bit low
  localparam logic [14:0] UART_BASE = 15'h4040;  // dev bit high
  localparam int          LIMIT     = 200;       // cycle bound of every wait

  logic               clk   = 1'b0;
  logic               reset = 1'b1;
  logic               lsb_vld;
  logic               lsb_wen;
  soc_adr_t           lsb_adr;
  soc_ben_t           lsb_ben;
  soc_data_t          lsb_wdt;
  soc_data_t          lsb_rdt;
  logic               lsb_err;
  logic [`SOC_GW-1:0] gpio_o;
  logic [`SOC_GW-1:0] gpio_e;
  logic [`SOC_GW-1:0] gpio_i;

  // one bus request per row, expected response checked a cycle later
  typedef struct {
    logic      vld;
    logic      wen;
    soc_adr_t  adr;
    soc_ben_t  ben;
    soc_data_t wdt;
    soc_data_t gpi;      // gpio_i driven with the row
    soc_data_t exp_rdt;
    logic      exp_err;
    soc_data_t exp_go;   // pins after the row is accepted
    soc_data_t exp_ge;
    int        test;
  } row_t;

  row_t      tbl [$];
  soc_data_t mem_model [int];  // written words only
  soc_data_t go_model = '0;
  soc_data_t ge_model = '0;
  soc_data_t cur_gpi  = '0;
  int        cur_test = 1;
  string     test_name [1:6];
  integer    seed        = 32'h050efafb;
  int        errors      = 0;
  int        checks      = 0;
  int        test_err    = 0;
  int        tests_done  = 0;
  int        chk_row     = -1;  // -1 is the check right after reset
  logic      done        = 1'b0;
  logic      rst_timeout = 1'b0;

  r5p_soc_top UUT (.*);

  initial begin : clock_gen
    forever #50 clk = ~clk;
  end

  initial begin : reset_gen
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic soc_data_t merge_bytes(soc_data_t old, soc_data_t wdt, soc_ben_t ben);
    soc_data_t res;
    res = old;
    for (int b = 0; b < `SOC_DBW; b++) begin
      if (ben[b]) res[8*b+:8] = wdt[8*b+:8];  // enabled lanes only
    end
    return res;
  endfunction

  task automatic push_row(input logic vld, input logic wen, input soc_adr_t adr,
                          input soc_ben_t ben, input soc_data_t wdt);
    row_t       r;
    int         w;
    logic [5:0] ofs;
    w   = int'(adr.mem.off >> 2);
    ofs = adr.per.ofs & 6'h3c;  // word aligned register offset
    r.vld = vld;
    r.wen = wen;
    r.adr = adr;
    r.ben = ben;
    r.wdt = wdt;
    r.gpi = cur_gpi;
    r.test = cur_test;
    r.exp_rdt = '0;  // writes, idle and errors read zero
    r.exp_err = 1'b0;
    if (vld && !adr.mem.sel) begin
      if (wen) mem_model[w] = merge_bytes(mem_model.exists(w) ? mem_model[w] : 'x, wdt, ben);
      else     r.exp_rdt = mem_model[w];
    end else if (vld && !adr.per.dev) begin
      if (wen && ofs == `SOC_GPIO_OUT) go_model = merge_bytes(go_model, wdt, ben);
      if (wen && ofs == `SOC_GPIO_ENA) ge_model = merge_bytes(ge_model, wdt, ben);
      if (!wen) begin
        case (ofs)
          `SOC_GPIO_OUT: r.exp_rdt = go_model;
          `SOC_GPIO_ENA: r.exp_rdt = ge_model;
          `SOC_GPIO_INP: r.exp_rdt = (tbl.size() >= 2) ? tbl[tbl.size()-2].gpi : '0;  // 2 sync stages
          default:       r.exp_rdt = '0;
        endcase
      end
    end else if (vld) begin
      r.exp_err = 1'b1;  // uart window
    end
    r.exp_go = go_model;
    r.exp_ge = ge_model;
    tbl.push_back(r);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    soc_data_t d [0:4];
    foreach (d[i]) d[i] = $random(seed);
    test_name[1] = "reset values";
    test_name[2] = "memory byte enables";
    test_name[3] = "gpio output and enable";
    test_name[4] = "gpio input and holes";
    test_name[5] = "uart window error";
    test_name[6] = "back to back reads";
    cur_test = 1;
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_OUT, 4'hf, '0);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_ENA, 4'hf, '0);
    cur_test = 2;
    push_row(1, 1, 15'h0000, 4'hf, d[0]);
    push_row(1, 1, 15'h0104, 4'hf, d[1]);
    push_row(1, 1, 15'h3ffc, 4'hf, d[2]);  // last memory word
    push_row(1, 0, 15'h0000, 4'hf, '0);
    push_row(1, 1, 15'h0104, 4'b0101, d[3]);
    push_row(1, 0, 15'h0104, 4'hf, '0);
    push_row(1, 1, 15'h0000, 4'b1000, d[4]);
    push_row(1, 0, 15'h0000, 4'hf, '0);
    push_row(1, 0, 15'h3ffc, 4'hf, '0);
    cur_test = 3;
    push_row(1, 1, GPIO_BASE + `SOC_GPIO_OUT, 4'hf, 32'h1234_5678);
    push_row(1, 1, GPIO_BASE + `SOC_GPIO_ENA, 4'hf, 32'hffff_0000);
    push_row(1, 1, GPIO_BASE + `SOC_GPIO_OUT, 4'b0010, 32'hdead_beef);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_OUT, 4'hf, '0);
    push_row(1, 1, GPIO_BASE + `SOC_GPIO_ENA, 4'b1100, 32'h00ab_cdef);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_ENA, 4'hf, '0);
    cur_test = 4;
    cur_gpi  = 32'h5a3c_96e1;  // held from here on
    repeat (3) push_row(0, 0, '0, '0, '0);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_INP, 4'hf, '0);
    push_row(1, 1, GPIO_BASE + `SOC_GPIO_INP, 4'hf, 32'hffff_ffff);  // read only
    push_row(1, 0, GPIO_BASE + 6'h0c, 4'hf, '0);
    push_row(1, 0, GPIO_BASE + 6'h3c, 4'hf, '0);
    cur_test = 5;
    push_row(1, 0, UART_BASE, 4'hf, '0);
    push_row(1, 1, UART_BASE + 6'h04, 4'hf, 32'h0000_0041);
    push_row(1, 0, 15'h7ffc, 4'hf, '0);
    push_row(1, 0, 15'h0104, 4'hf, '0);  // memory again, no error
    cur_test = 6;
    push_row(1, 0, 15'h0104, 4'hf, '0);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_OUT, 4'hf, '0);
    push_row(1, 0, 15'h3ffc, 4'hf, '0);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_ENA, 4'hf, '0);
    push_row(1, 0, 15'h0000, 4'hf, '0);
    push_row(1, 0, GPIO_BASE + `SOC_GPIO_INP, 4'hf, '0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_err++;
      $display("MISMATCH %s row %0d: got %h, expected %h", name, chk_row, got, exp);
    end
  endtask

  task automatic check_row(input int r);
    chk_row = r;
    compare("lsb_rdt", lsb_rdt, tbl[r].exp_rdt);
    compare("lsb_err", lsb_err, tbl[r].exp_err);
    compare("gpio_o", gpio_o, tbl[r].exp_go);
    compare("gpio_e", gpio_e, tbl[r].exp_ge);
    if (r == tbl.size() - 1 || tbl[r+1].test != tbl[r].test) begin  // last row of a test
      $display("test %0d %s: %s, %0d mismatches", tbl[r].test, test_name[tbl[r].test],
               (test_err == 0) ? "ok" : "FAIL", test_err);
      tests_done++;
      test_err = 0;
    end
  endtask

  initial begin : stimulus
    int unsigned cyc;
    lsb_vld = 1'b0;  // bus idle until reset is gone
    lsb_wen = 1'b0;
    lsb_adr = '0;
    lsb_ben = '0;
    lsb_wdt = '0;
    gpio_i  = '0;
    fill_table();
    cyc = 0;
    while (reset && cyc < LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    if (reset) begin
      rst_timeout = 1'b1;
    end else begin
      @(negedge clk);
      compare("lsb_err", lsb_err, 1'b0);  // first cycle out of reset
      compare("gpio_o", gpio_o, '0);
      compare("gpio_e", gpio_e, '0);
      for (int r = 0; r <= tbl.size(); r++) begin
        @(posedge clk);
        if (r < tbl.size()) begin
          lsb_vld <= tbl[r].vld;
          lsb_wen <= tbl[r].wen;
          lsb_adr <= tbl[r].adr;
          lsb_ben <= tbl[r].ben;
          lsb_wdt <= tbl[r].wdt;
          gpio_i  <= tbl[r].gpi;
        end else begin
          lsb_vld <= 1'b0;  // drain the last response
        end
        @(negedge clk);
        if (r > 0) check_row(r - 1);  // response of the row accepted at this edge
      end
    end
    done = 1'b1;
  end

  initial begin : main
    int unsigned cyc;
    cyc = 0;
    while (!done && cyc < 2 * LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    if (!done) $display("timeout: the stimulus table did not finish in %0d cycles", 2 * LIMIT);
    if (rst_timeout) $display("timeout: reset was never released");
    $display("%0d tests, %0d checks, %0d mismatches", tests_done, checks, errors);
    if (done && !rst_timeout && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule: soc_tb
